/* rtl/riscv_pkg.sv */
package riscv_pkg;

    // Machine word and register index widths.
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ALU_OP_W   = 4;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [31:0]           instr_t;

    // Compare operations return a single bit in the result LSB.
    typedef enum logic [ALU_OP_W-1:0] {
        ALU_PASS = 4'd0,
        ALU_ADD  = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_SLL  = 4'd3,
        ALU_SRL  = 4'd4,
        ALU_SRA  = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_OR   = 4'd7,
        ALU_AND  = 4'd8,
        ALU_EQ   = 4'd9,
        ALU_NE   = 4'd10,
        ALU_LTS  = 4'd11,
        ALU_LTU  = 4'd12,
        ALU_GES  = 4'd13,
        ALU_GEU  = 4'd14
    } alu_op_e;

    // Major opcodes.
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // funct3 for OP and OP-IMM.
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // SRL or SRA by funct7.
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3 for BRANCH.
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Selects SUB and SRA.
    localparam logic [6:0] F7_ALT = 7'b0100000;

endpackage

/* rtl/alu.sv */
`timescale 1ns/1ps

module alu (
    input  riscv_pkg::alu_op_e alu_op_i,

    input  riscv_pkg::word_t   operand_a_i,
    input  riscv_pkg::word_t   operand_b_i,

    output riscv_pkg::word_t   alu_result_o
);

    import riscv_pkg::*;

    logic [XLEN:0] adder_in_a;
    logic [XLEN:0] adder_in_b;
    logic [XLEN:0] adder_result;
    word_t         adder_out;
    logic          negate_op_b;

    logic [4:0]    shamt;
    word_t         shift_out;

    logic          signed_op;
    logic          is_equal;
    logic          is_greater_equal;
    logic          comp_result;

    // Carry-in rides in the extra LSB so one adder also subtracts.
    always_comb
    begin
        negate_op_b  = (alu_op_i != ALU_ADD); // Compares subtract too.
        adder_in_a   = {operand_a_i, 1'b1};
        adder_in_b   = {operand_b_i ^ {XLEN{negate_op_b}}, negate_op_b};
        adder_result = adder_in_a + adder_in_b;
        adder_out    = adder_result[XLEN:1];
    end

    assign shamt = operand_b_i[4:0]; // Upper bits ignored.

    always_comb
    begin
        case (alu_op_i)
            ALU_SRA: shift_out = $signed(operand_a_i) >>> shamt;
            ALU_SRL: shift_out = operand_a_i >> shamt;
            ALU_SLL: shift_out = operand_a_i << shamt;
            default: shift_out = '0;
        endcase
    end

    assign signed_op = (alu_op_i == ALU_GES) || (alu_op_i == ALU_LTS);
    assign is_equal  = (operand_a_i == operand_b_i);

    // With equal signs the difference decides, otherwise the signs do.
    always_comb
    begin
        if ((operand_a_i[XLEN-1] ^ operand_b_i[XLEN-1]) == 1'b0)
        begin
            is_greater_equal = ~adder_out[XLEN-1];
        end
        else
        begin
            is_greater_equal = operand_a_i[XLEN-1] ^ signed_op;
        end
    end

    always_comb
    begin
        case (alu_op_i)
            ALU_EQ:           comp_result = is_equal;
            ALU_NE:           comp_result = ~is_equal;
            ALU_GES, ALU_GEU: comp_result = is_greater_equal;
            ALU_LTS, ALU_LTU: comp_result = ~is_greater_equal;
            default:          comp_result = 1'b0;
        endcase
    end

    always_comb
    begin
        case (alu_op_i)
            ALU_PASS:                  alu_result_o = operand_a_i;
            ALU_ADD, ALU_SUB:          alu_result_o = adder_out;
            ALU_SRA, ALU_SRL, ALU_SLL: alu_result_o = shift_out;
            ALU_XOR:                   alu_result_o = operand_a_i ^ operand_b_i;
            ALU_OR:                    alu_result_o = operand_a_i | operand_b_i;
            ALU_AND:                   alu_result_o = operand_a_i & operand_b_i;
            ALU_EQ, ALU_NE,
            ALU_GES, ALU_GEU,
            ALU_LTS, ALU_LTU:          alu_result_o = {{(XLEN-1){1'b0}}, comp_result};
            default:                   alu_result_o = '0;
        endcase
    end

endmodule

/* rtl/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
    input  riscv_pkg::instr_t    instr_i,

    output riscv_pkg::reg_addr_t rs1_o,
    output riscv_pkg::reg_addr_t rs2_o,
    output riscv_pkg::reg_addr_t rd_o,
    output riscv_pkg::word_t     imm_o,
    output riscv_pkg::alu_op_e   alu_op_o,

    output logic                 use_imm_o,
    output logic                 use_pc_o,
    output logic                 zero_a_o,
    output logic                 reg_write_o,
    output logic                 is_branch_o,
    output logic                 illegal_o
);

    import riscv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i_type;
    word_t      imm_u_type;
    word_t      imm_b_type;

    // Shared by OP and OP-IMM.
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_LTS;
            F3_SLTU: return ALU_LTU;
            F3_XOR:  return ALU_XOR;
            F3_SR:   return alt ? ALU_SRA : ALU_SRL;
            F3_OR:   return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign rd_o  = instr_i[11:7];
    assign rs1_o = instr_i[19:15];
    assign rs2_o = instr_i[24:20];

    assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_u_type = {instr_i[31:12], 12'b0};
    assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0};

    always_comb
    begin
        imm_o       = '0;
        alu_op_o    = ALU_ADD;
        use_imm_o   = 1'b0;
        use_pc_o    = 1'b0;
        zero_a_o    = 1'b0;
        reg_write_o = 1'b0;
        is_branch_o = 1'b0;
        illegal_o   = 1'b0;

        case (opcode)
            OPC_OP:
            begin
                alu_op_o    = arith_op(funct3, funct7 == F7_ALT);
                reg_write_o = 1'b1;
                if (funct7 == F7_ALT)
                    illegal_o = (funct3 != F3_ADD) && (funct3 != F3_SR);
                else
                    illegal_o = (funct7 != '0);
            end
            OPC_OP_IMM:
            begin
                imm_o       = imm_i_type;
                use_imm_o   = 1'b1;
                alu_op_o    = arith_op(funct3, (funct3 == F3_SR) && (funct7 == F7_ALT));
                reg_write_o = 1'b1;
                // Only the shift forms reuse funct7.
                if (funct3 == F3_SLL)
                    illegal_o = (funct7 != '0);
                else if (funct3 == F3_SR)
                    illegal_o = (funct7 != '0) && (funct7 != F7_ALT);
            end
            OPC_LUI:
            begin
                imm_o       = imm_u_type;
                use_imm_o   = 1'b1;
                zero_a_o    = 1'b1; // 0 + imm.
                reg_write_o = 1'b1;
            end
            OPC_AUIPC:
            begin
                imm_o       = imm_u_type;
                use_imm_o   = 1'b1;
                use_pc_o    = 1'b1;
                reg_write_o = 1'b1;
            end
            OPC_BRANCH:
            begin
                imm_o       = imm_b_type;
                is_branch_o = 1'b1;
                case (funct3)
                    F3_BEQ:  alu_op_o = ALU_EQ;
                    F3_BNE:  alu_op_o = ALU_NE;
                    F3_BLT:  alu_op_o = ALU_LTS;
                    F3_BGE:  alu_op_o = ALU_GES;
                    F3_BLTU: alu_op_o = ALU_LTU;
                    F3_BGEU: alu_op_o = ALU_GEU;
                    default: illegal_o = 1'b1;
                endcase
            end
            default: illegal_o = 1'b1;
        endcase

        if (illegal_o)
        begin
            reg_write_o = 1'b0; // Leave rd untouched.
            is_branch_o = 1'b0;
        end
    end

endmodule

/* rtl/register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    input  riscv_pkg::reg_addr_t raddr_a_i,
    input  riscv_pkg::reg_addr_t raddr_b_i,
    output riscv_pkg::word_t     rdata_a_o,
    output riscv_pkg::word_t     rdata_b_o,

    input  riscv_pkg::reg_addr_t waddr_i,
    input  logic                 we_i,
    input  riscv_pkg::word_t     wdata_i
);

    import riscv_pkg::*;

    // No storage for x0.
    word_t regs_q [1:2**REG_ADDR_W-1];

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            for (int i = 1; i < 2**REG_ADDR_W; i++)
            begin
                regs_q[i] <= '0;
            end
        end
        else if (we_i && (waddr_i != '0))
        begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

/* rtl/exec_stage.sv */
`timescale 1ns/1ps

module exec_stage (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    input  logic                 instr_valid_i,
    input  riscv_pkg::word_t     pc_i,
    input  riscv_pkg::word_t     rs1_data_i,
    input  riscv_pkg::word_t     rs2_data_i,
    input  riscv_pkg::word_t     imm_i,
    input  logic                 use_imm_i,
    input  logic                 use_pc_i,
    input  logic                 zero_a_i,
    input  logic                 reg_write_i,
    input  logic                 is_branch_i,
    input  logic                 illegal_i,
    input  riscv_pkg::reg_addr_t rd_i,
    input  riscv_pkg::word_t     alu_result_i,

    output riscv_pkg::word_t     operand_a_o,
    output riscv_pkg::word_t     operand_b_o,
    output logic                 rf_we_o,

    output logic                 wb_valid_o,
    output riscv_pkg::reg_addr_t wb_rd_o,
    output riscv_pkg::word_t     wb_data_o,
    output logic                 branch_taken_o,
    output riscv_pkg::word_t     branch_target_o,
    output logic                 illegal_o
);

    import riscv_pkg::*;

    word_t branch_target;
    logic  do_write;

    assign operand_a_o = zero_a_i ? '0 : (use_pc_i ? pc_i : rs1_data_i);
    assign operand_b_o = (use_imm_i && !is_branch_i) ? imm_i : rs2_data_i;

    // ALU is busy comparing, so the target gets its own adder.
    assign branch_target = pc_i + imm_i;

    assign do_write = instr_valid_i && reg_write_i && !illegal_i;
    assign rf_we_o  = do_write && (rd_i != '0);

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            wb_valid_o      <= 1'b0;
            wb_rd_o         <= '0;
            wb_data_o       <= '0;
            branch_taken_o  <= 1'b0;
            branch_target_o <= '0;
            illegal_o       <= 1'b0;
        end
        else
        begin
            wb_valid_o     <= do_write;
            branch_taken_o <= instr_valid_i && is_branch_i && alu_result_i[0];
            illegal_o      <= instr_valid_i && illegal_i;
            if (do_write)
            begin
                wb_rd_o   <= rd_i;
                wb_data_o <= alu_result_i;
            end
            if (instr_valid_i && is_branch_i)
                branch_target_o <= branch_target; // Taken or not.
        end
    end

endmodule

/* rtl/riscv_exec_top.sv */
`timescale 1ns/1ps

module riscv_exec_top (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    input  logic                 instr_valid_i,
    input  riscv_pkg::instr_t    instr_i,
    input  riscv_pkg::word_t     pc_i,

    output logic                 wb_valid_o,
    output riscv_pkg::reg_addr_t wb_rd_o,
    output riscv_pkg::word_t     wb_data_o,
    output logic                 branch_taken_o,
    output riscv_pkg::word_t     branch_target_o,
    output logic                 illegal_o
);

    import riscv_pkg::*;

    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;
    alu_op_e   alu_op;
    logic      use_imm;
    logic      use_pc;
    logic      zero_a;
    logic      reg_write;
    logic      is_branch;
    logic      dec_illegal;

    word_t     rs1_data;
    word_t     rs2_data;
    word_t     operand_a;
    word_t     operand_b;
    word_t     alu_result;
    logic      rf_we;

    instr_decoder i_decoder (
        .instr_i     (instr_i),
        .rs1_o       (rs1),
        .rs2_o       (rs2),
        .rd_o        (rd),
        .imm_o       (imm),
        .alu_op_o    (alu_op),
        .use_imm_o   (use_imm),
        .use_pc_o    (use_pc),
        .zero_a_o    (zero_a),
        .reg_write_o (reg_write),
        .is_branch_o (is_branch),
        .illegal_o   (dec_illegal)
    );

    // Write data comes straight from the ALU.
    register_file i_regfile (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .raddr_a_i (rs1),
        .raddr_b_i (rs2),
        .rdata_a_o (rs1_data),
        .rdata_b_o (rs2_data),
        .waddr_i   (rd),
        .we_i      (rf_we),
        .wdata_i   (alu_result)
    );

    exec_stage i_exec (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .instr_valid_i   (instr_valid_i),
        .pc_i            (pc_i),
        .rs1_data_i      (rs1_data),
        .rs2_data_i      (rs2_data),
        .imm_i           (imm),
        .use_imm_i       (use_imm),
        .use_pc_i        (use_pc),
        .zero_a_i        (zero_a),
        .reg_write_i     (reg_write),
        .is_branch_i     (is_branch),
        .illegal_i       (dec_illegal),
        .rd_i            (rd),
        .alu_result_i    (alu_result),
        .operand_a_o     (operand_a),
        .operand_b_o     (operand_b),
        .rf_we_o         (rf_we),
        .wb_valid_o      (wb_valid_o),
        .wb_rd_o         (wb_rd_o),
        .wb_data_o       (wb_data_o),
        .branch_taken_o  (branch_taken_o),
        .branch_target_o (branch_target_o),
        .illegal_o       (illegal_o)
    );

    alu i_alu (
        .alu_op_i     (alu_op),
        .operand_a_i  (operand_a),
        .operand_b_i  (operand_b),
        .alu_result_o (alu_result)
    );

endmodule

/* verification/tb_riscv_exec.sv */
`timescale 1ns/1ps

module tb_riscv_exec;

    localparam int CLK_HALF     = 20;
    localparam int RESET_CYCLES = 5;
    localparam int MAX_TESTS    = 80;

    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;

    logic        clk_i;
    logic        rst_n_i;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic [31:0] pc_i;
    logic        wb_valid_o;
    logic [4:0]  wb_rd_o;
    logic [31:0] wb_data_o;
    logic        branch_taken_o;
    logic [31:0] branch_target_o;
    logic        illegal_o;

    string       test_name   [MAX_TESTS];
    logic [31:0] test_instr  [MAX_TESTS];
    logic [31:0] test_pc     [MAX_TESTS];
    logic        exp_wb      [MAX_TESTS];
    logic [4:0]  exp_rd      [MAX_TESTS];
    logic [31:0] exp_data    [MAX_TESTS];
    logic        exp_taken   [MAX_TESTS];
    logic        chk_target  [MAX_TESTS]; // Only branches move the target.
    logic [31:0] exp_target  [MAX_TESTS];
    logic        exp_illegal [MAX_TESTS];
    int          num_tests;

    logic [15:0] lfsr_state;
    int          error_count;
    int          failed_tests;
    int          cycle_count = 0;
    int          timeout_limit;

    riscv_exec_top i_dut (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .instr_valid_i   (instr_valid_i),
        .instr_i         (instr_i),
        .pc_i            (pc_i),
        .wb_valid_o      (wb_valid_o),
        .wb_rd_o         (wb_rd_o),
        .wb_data_o       (wb_data_o),
        .branch_taken_o  (branch_taken_o),
        .branch_target_o (branch_target_o),
        .illegal_o       (illegal_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #CLK_HALF clk_i = ~clk_i;
    end

    always @(posedge clk_i)
    begin
        cycle_count++;
        if (cycle_count > timeout_limit)
        begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(input int nbits, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic add_test(input string name, input logic [31:0] instr,
                            input logic [31:0] pc, input logic wb, input logic [4:0] rd,
                            input logic [31:0] data, input logic taken,
                            input logic chk_tgt, input logic [31:0] target,
                            input logic ill);
        test_name[num_tests]   = name;
        test_instr[num_tests]  = instr;
        test_pc[num_tests]     = pc;
        exp_wb[num_tests]      = wb;
        exp_rd[num_tests]      = rd;
        exp_data[num_tests]    = data;
        exp_taken[num_tests]   = taken;
        chk_target[num_tests]  = chk_tgt;
        exp_target[num_tests]  = target;
        exp_illegal[num_tests] = ill;
        num_tests++;
    endtask

    task automatic add_wb(input string name, input logic [31:0] instr,
                          input logic [31:0] pc, input logic [4:0] rd,
                          input logic [31:0] data);
        add_test(name, instr, pc, 1'b1, rd, data, 1'b0, 1'b0, '0, 1'b0);
    endtask

    task automatic add_branch(input string name, input logic [31:0] instr,
                              input logic [31:0] pc, input logic taken,
                              input logic [31:0] target);
        add_test(name, instr, pc, 1'b0, '0, '0, taken, 1'b1, target, 1'b0);
    endtask

    task automatic add_illegal(input string name, input logic [31:0] instr);
        add_test(name, instr, '0, 1'b0, '0, '0, 1'b0, 1'b0, '0, 1'b1);
    endtask

    task automatic build_table();
        logic [31:0] r;
        logic [31:0] imm_ext;
        add_wb("read_x1_reset", enc_r(7'h00, 5'd0, 5'd1, 3'b000, 5'd3), '0, 5'd3, 32'h0);
        add_wb("addi_x1", enc_i(12'd5, 5'd0, 3'b000, 5'd1), '0, 5'd1, 32'h5);
        add_wb("addi_x2_neg", enc_i(12'hFFD, 5'd0, 3'b000, 5'd2), '0, 5'd2, 32'hFFFF_FFFD);
        add_wb("lui_x4", enc_u(20'h80000, 5'd4, OP_LUI), '0, 5'd4, 32'h8000_0000);
        add_wb("addi_x5", enc_i(12'd1, 5'd0, 3'b000, 5'd5), '0, 5'd5, 32'h1);
        add_wb("lui_x6", enc_u(20'h12345, 5'd6, OP_LUI), '0, 5'd6, 32'h1234_5000);
        add_wb("addi_x6_dep", enc_i(12'h678, 5'd6, 3'b000, 5'd6), '0, 5'd6, 32'h1234_5678);
        add_wb("addi_x22", enc_i(12'd36, 5'd0, 3'b000, 5'd22), '0, 5'd22, 32'h24);
        add_wb("add", enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd7), '0, 5'd7, 32'h2);
        add_wb("sub", enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd8), '0, 5'd8, 32'h8);
        add_wb("sub_wrap", enc_r(7'h20, 5'd5, 5'd4, 3'b000, 5'd9), '0, 5'd9, 32'h7FFF_FFFF);
        add_wb("sub_neg", enc_r(7'h20, 5'd5, 5'd0, 3'b000, 5'd10), '0, 5'd10, 32'hFFFF_FFFF);
        add_wb("xor", enc_r(7'h00, 5'd2, 5'd6, 3'b100, 5'd11), '0, 5'd11, 32'hEDCB_A985);
        add_wb("or", enc_r(7'h00, 5'd6, 5'd1, 3'b110, 5'd12), '0, 5'd12, 32'h1234_567D);
        add_wb("and", enc_r(7'h00, 5'd2, 5'd6, 3'b111, 5'd13), '0, 5'd13, 32'h1234_5678);
        add_wb("andi", enc_i(12'h0F0, 5'd6, 3'b111, 5'd16), '0, 5'd16, 32'h70);
        add_wb("ori", enc_i(12'h700, 5'd1, 3'b110, 5'd14), '0, 5'd14, 32'h705);
        add_wb("xori_not", enc_i(12'hFFF, 5'd6, 3'b100, 5'd15), '0, 5'd15, 32'hEDCB_A987);
        // Immediate sweep against x6 and x2.
        for (int k = 0; k < 4; k++)
        begin
            random_bits(12, r);
            imm_ext = {{20{r[11]}}, r[11:0]};
            add_wb($sformatf("addi_rand_%0d", k), enc_i(r[11:0], 5'd6, 3'b000, 5'd10), '0,
                   5'd10, 32'h1234_5678 + imm_ext);
            random_bits(12, r);
            imm_ext = {{20{r[11]}}, r[11:0]};
            add_wb($sformatf("xori_rand_%0d", k), enc_i(r[11:0], 5'd2, 3'b100, 5'd11), '0,
                   5'd11, 32'hFFFF_FFFD ^ imm_ext);
        end
        add_wb("sll_neg", enc_r(7'h00, 5'd1, 5'd2, 3'b001, 5'd17), '0, 5'd17, 32'hFFFF_FFA0);
        add_wb("srl_neg", enc_r(7'h00, 5'd1, 5'd2, 3'b101, 5'd18), '0, 5'd18, 32'h07FF_FFFF);
        add_wb("sra_neg", enc_r(7'h20, 5'd1, 5'd2, 3'b101, 5'd19), '0, 5'd19, 32'hFFFF_FFFF);
        add_wb("sra_shamt36", enc_r(7'h20, 5'd22, 5'd4, 3'b101, 5'd20), '0,
               5'd20, 32'hF800_0000);
        add_wb("srl_shamt36", enc_r(7'h00, 5'd22, 5'd4, 3'b101, 5'd21), '0,
               5'd21, 32'h0800_0000);
        add_wb("sll_shamt36", enc_r(7'h00, 5'd22, 5'd6, 3'b001, 5'd23), '0,
               5'd23, 32'h2345_6780);
        add_wb("slli", enc_i(12'h008, 5'd6, 3'b001, 5'd24), '0, 5'd24, 32'h3456_7800);
        add_wb("srai", enc_i(12'h41F, 5'd4, 3'b101, 5'd25), '0, 5'd25, 32'hFFFF_FFFF);
        add_wb("srli", enc_i(12'h01F, 5'd4, 3'b101, 5'd26), '0, 5'd26, 32'h1);
        add_wb("slt_min_1", enc_r(7'h00, 5'd5, 5'd4, 3'b010, 5'd27), '0, 5'd27, 32'h1);
        add_wb("sltu_min_1", enc_r(7'h00, 5'd5, 5'd4, 3'b011, 5'd28), '0, 5'd28, 32'h0);
        add_wb("slti", enc_i(12'hFFE, 5'd2, 3'b010, 5'd29), '0, 5'd29, 32'h1);
        add_wb("sltiu", enc_i(12'hFFF, 5'd5, 3'b011, 5'd30), '0, 5'd30, 32'h1);
        add_wb("slt_1_min", enc_r(7'h00, 5'd4, 5'd5, 3'b010, 5'd31), '0, 5'd31, 32'h0);
        add_branch("beq_taken", enc_b(13'd16, 5'd1, 5'd1, 3'b000), 32'h100, 1'b1, 32'h110);
        add_branch("bne_not", enc_b(13'd16, 5'd1, 5'd1, 3'b001), 32'h104, 1'b0, 32'h114);
        add_branch("bne_taken", enc_b(13'hFFE, 5'd2, 5'd1, 3'b001), 32'h500, 1'b1, 32'h14FE);
        add_branch("blt_taken", enc_b(13'h1FF8, 5'd5, 5'd4, 3'b100), 32'h200, 1'b1, 32'h1F8);
        add_branch("bge_not", enc_b(13'h020, 5'd5, 5'd4, 3'b101), 32'h204, 1'b0, 32'h224);
        add_branch("bltu_not", enc_b(13'h800, 5'd5, 5'd4, 3'b110), 32'h300, 1'b0, 32'hB00);
        add_branch("bgeu_taken", enc_b(13'h1000, 5'd5, 5'd4, 3'b111), 32'h2000, 1'b1, 32'h1000);
        add_wb("addi_x0", enc_i(12'd7, 5'd1, 3'b000, 5'd0), '0, 5'd0, 32'hC); // Reported, not stored.
        add_wb("read_x0", enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd3), '0, 5'd3, 32'h0);
        add_wb("lui", enc_u(20'hABCDE, 5'd7, OP_LUI), '0, 5'd7, 32'hABCD_E000);
        add_wb("auipc", enc_u(20'h00001, 5'd8, OP_AUIPC), 32'h400, 5'd8, 32'h1400);
        add_wb("auipc_neg", enc_u(20'hFFFFF, 5'd9, OP_AUIPC), 32'h10, 5'd9, 32'hFFFF_F010);
        add_illegal("bad_opcode", 32'h0000_00FF); // rd is x1.
        add_illegal("slli_alt_f7", enc_i(12'h403, 5'd1, 3'b001, 5'd1));
        add_illegal("xor_alt_f7", enc_r(7'h20, 5'd2, 5'd1, 3'b100, 5'd1));
        add_illegal("branch_bad_f3", enc_b(13'd16, 5'd1, 5'd1, 3'b010));
        add_wb("readback_x1", enc_r(7'h00, 5'd0, 5'd1, 3'b000, 5'd3), '0, 5'd3, 32'h5);
    endtask

    task automatic check_value(input string name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("Mismatch %s %s: expected 0x%08h, actual 0x%08h",
                     name, field, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before)
        begin
            $display("test %s: ok", name);
        end
        else
        begin
            $display("test %s: %0d mismatches", name, error_count - errors_before);
            failed_tests++;
        end
    endtask

    task automatic check_entry(input int idx);
        int errors_before;
        errors_before = error_count;
        check_value(test_name[idx], "wb_valid", exp_wb[idx], wb_valid_o);
        check_value(test_name[idx], "branch_taken", exp_taken[idx], branch_taken_o);
        check_value(test_name[idx], "illegal", exp_illegal[idx], illegal_o);
        if (exp_wb[idx])
        begin
            check_value(test_name[idx], "wb_rd", exp_rd[idx], wb_rd_o);
            check_value(test_name[idx], "wb_data", exp_data[idx], wb_data_o);
        end
        if (chk_target[idx])
            check_value(test_name[idx], "branch_target", exp_target[idx], branch_target_o);
        report_test(test_name[idx], errors_before);
    endtask

    task automatic check_idle(input string name, input logic check_data);
        int errors_before;
        errors_before = error_count;
        check_value(name, "wb_valid", 1'b0, wb_valid_o);
        check_value(name, "branch_taken", 1'b0, branch_taken_o);
        check_value(name, "illegal", 1'b0, illegal_o);
        if (check_data)
        begin
            check_value(name, "wb_rd", '0, wb_rd_o);
            check_value(name, "wb_data", '0, wb_data_o);
            check_value(name, "branch_target", '0, branch_target_o);
        end
        report_test(name, errors_before);
    endtask

    initial
    begin
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        error_count   = 0;
        failed_tests  = 0;
        num_tests     = 0;
        lfsr_state    = 16'd5;
        build_table();
        timeout_limit = num_tests + RESET_CYCLES + 20;

        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        check_idle("reset_values", 1'b1);

        // Back-to-back strobes, one entry per cycle.
        for (int i = 0; i < num_tests; i++)
        begin
            instr_valid_i = 1'b1;
            instr_i       = test_instr[i];
            pc_i          = test_pc[i];
            @(negedge clk_i);
            check_entry(i);
        end
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        @(negedge clk_i);
        check_idle("pulses_end", 1'b0);

        $display("Tests: %0d, passed: %0d, failed: %0d, mismatches: %0d",
                 num_tests + 2, num_tests + 2 - failed_tests, failed_tests, error_count);
        if (error_count == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* tb.f */
rtl/riscv_pkg.sv
rtl/alu.sv
rtl/instr_decoder.sv
rtl/register_file.sv
rtl/exec_stage.sv
rtl/riscv_exec_top.sv
verification/tb_riscv_exec.sv

/* Bender.yml */
package:
  name: riscv_exec

sources:
  - rtl/riscv_pkg.sv
  - rtl/alu.sv
  - rtl/instr_decoder.sv
  - rtl/register_file.sv
  - rtl/exec_stage.sv
  - rtl/riscv_exec_top.sv
  - target: test
    files:
      - verification/tb_riscv_exec.sv
